//--- source/rename_pkg.sv
`default_nettype none

package rename_pkg;

    localparam int NUM_LANES = 2;   // dispatch, complete and retire width
    localparam int ARCH_REGS = 8;   // architectural registers
    localparam int PHYS_REGS = 16;  // physical registers
    localparam int ARCH_BITS = 3;
    localparam int TAG_BITS  = 4;

    // wide enough to count every physical register as free
    localparam int COUNT_BITS = $clog2(PHYS_REGS + 1);

    typedef logic [ARCH_BITS-1:0] arch_idx_t;  // architectural register index
    typedef logic [TAG_BITS-1:0]  phys_tag_t;  // physical register tag
    typedef logic [PHYS_REGS-1:0] phys_vec_t;  // one bit per physical register

    // after reset arch reg i sits in tag i, so the low tags hold values
    localparam phys_vec_t RESET_READY = phys_vec_t'((1 << ARCH_REGS) - 1);
    localparam phys_vec_t RESET_FREE  = ~RESET_READY;  // upper tags start in the pool

endpackage

`default_nettype wire

//--- source/alloc_if.sv
`timescale 1ns/10ps
`default_nettype none

// tag requests from the map table, grants and ready status back from the free list
interface alloc_if import rename_pkg::*; ();

    logic      [NUM_LANES-1:0] req;         // lane wants a new destination tag
    phys_tag_t [NUM_LANES-1:0] tag;         // tag offered to each lane
    logic                      ok;          // whole group can be granted this cycle
    phys_vec_t                 ready_list;  // registered ready bits, one per tag

    modport requester (
        output req,
        input  tag,
        input  ok,
        input  ready_list
    );

    modport provider (
        input  req,
        output tag,
        output ok,
        output ready_list
    );

endinterface

`default_nettype wire

//--- source/psel_gen.sv
`timescale 1ns/10ps
`default_nettype none

// picks the lowest free physical registers, one per grant slot, and encodes them
module psel_gen import rename_pkg::*; (
    input  phys_vec_t                 free_vec,     // free list bits
    output phys_tag_t [NUM_LANES-1:0] grant_tag,    // slot 0 lowest, slot 1 next lowest
    output logic      [NUM_LANES-1:0] grant_valid   // enough free bits for this slot
);

    always_comb begin
        phys_vec_t remaining;  // free bits not yet taken by a lower slot

        remaining = free_vec;
        for (int slot = 0; slot < NUM_LANES; slot++) begin
            grant_tag[slot]   = '0;
            grant_valid[slot] = 1'b0;

            // scan from the top down so the lowest set bit is written last
            for (int i = PHYS_REGS - 1; i >= 0; i--) begin
                if (remaining[i]) begin
                    grant_tag[slot]   = phys_tag_t'(i);  // priority encode
                    grant_valid[slot] = 1'b1;
                end
            end

            if (grant_valid[slot]) begin
                remaining[grant_tag[slot]] = 1'b0;  // hide from the next slot
            end
        end
    end

endmodule

`default_nettype wire

//--- source/free_list.sv
`timescale 1ns/10ps
`default_nettype none

// free and ready vectors of the physical register file
module free_list import rename_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    alloc_if.provider                 alloc,
    input  logic      [NUM_LANES-1:0] complete_valid,      // writeback broadcast
    input  phys_tag_t [NUM_LANES-1:0] complete_tag,
    input  logic      [NUM_LANES-1:0] retire_valid,        // old tags released at commit
    input  phys_tag_t [NUM_LANES-1:0] retire_tag,
    input  logic                      checkpoint_take,     // branch dispatched this cycle
    input  logic                      mispredict_restore,  // branch resolved wrong
    output logic     [COUNT_BITS-1:0] free_count
);

    phys_vec_t                 free_vec;     // 1 = tag may be granted
    phys_vec_t                 ready_vec;    // 1 = tag holds a completed value
    phys_vec_t                 ckpt_free;    // free list saved at the branch
    phys_vec_t                 alloc_vec;    // tags granted this cycle
    phys_vec_t                 post_free;    // after dispatch and retire
    phys_vec_t                 next_free;
    phys_vec_t                 next_ready;
    phys_tag_t [NUM_LANES-1:0] grant_tag;
    logic      [NUM_LANES-1:0] grant_valid;
    logic      [NUM_LANES-1:0] fire;         // lane actually takes its tag
    logic     [COUNT_BITS-1:0] num_req;

    psel_gen u_psel (
        .free_vec    (free_vec),
        .grant_tag   (grant_tag),
        .grant_valid (grant_valid)
    );

    // population counts of the free list and the request group
    always_comb begin
        free_count = '0;
        for (int i = 0; i < PHYS_REGS; i++) begin
            free_count = free_count + COUNT_BITS'(free_vec[i]);
        end
        num_req = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            num_req = num_req + COUNT_BITS'(alloc.req[l]);
        end
    end

    // all or none, and nothing moves while the map is being restored
    assign alloc.ok = (free_count >= num_req) && !mispredict_restore;

    assign alloc.ready_list = ready_vec;

    // requesting lanes take grant slots in lane order, idle lanes skip none
    always_comb begin
        int slot;

        slot      = 0;
        alloc_vec = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            alloc.tag[l] = grant_tag[slot];
            fire[l]      = alloc.ok && alloc.req[l] && grant_valid[slot];
            if (fire[l]) begin
                alloc_vec[grant_tag[slot]] = 1'b1;
            end
            if (alloc.req[l]) begin
                slot = slot + 1;  // next requester gets the next lowest tag
            end
        end
    end

    always_comb begin
        post_free  = free_vec & ~alloc_vec;
        next_ready = ready_vec;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (retire_valid[l]) begin
                post_free[retire_tag[l]] = 1'b1;
            end
            if (complete_valid[l]) begin
                next_ready[complete_tag[l]] = 1'b1;
            end
        end
        next_ready = next_ready & ~alloc_vec;  // new tag has no value yet

        // tags handed out after the branch go back to the pool
        next_free = mispredict_restore ? (post_free | ckpt_free) : post_free;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            free_vec  <= RESET_FREE;
            ready_vec <= RESET_READY;
            ckpt_free <= RESET_FREE;
        end else begin
            free_vec  <= next_free;
            ready_vec <= next_ready;
            if (checkpoint_take) begin
                ckpt_free <= post_free;  // includes this cycle's retires
            end
        end
    end

endmodule

`default_nettype wire

//--- source/map_table.sv
`timescale 1ns/10ps
`default_nettype none

// architectural to physical map with one branch checkpoint
module map_table import rename_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  logic      [NUM_LANES-1:0] dispatch_valid,
    input  arch_idx_t [NUM_LANES-1:0] dest_arch,
    input  arch_idx_t [NUM_LANES-1:0] src_arch,
    input  logic                      checkpoint_take,
    input  logic                      mispredict_restore,
    alloc_if.requester                alloc,
    output logic                      dispatch_ok,
    output phys_tag_t [NUM_LANES-1:0] dest_tag,    // new tag per lane
    output phys_tag_t [NUM_LANES-1:0] old_tag,     // tag freed when the lane retires
    output phys_tag_t [NUM_LANES-1:0] src_tag,
    output logic      [NUM_LANES-1:0] src_ready
);

    phys_tag_t map      [ARCH_REGS];  // speculative map
    phys_tag_t ckpt_map [ARCH_REGS];  // copy taken at the branch
    phys_tag_t next_map [ARCH_REGS];

    assign alloc.req   = dispatch_valid;  // every valid lane writes a destination
    assign dispatch_ok = alloc.ok;
    assign dest_tag    = alloc.tag;

    // lookups, with bypass from older lanes of the same group
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            src_tag[l]   = map[src_arch[l]];
            old_tag[l]   = map[dest_arch[l]];
            src_ready[l] = alloc.ready_list[src_tag[l]];

            // youngest older writer is visited last and wins
            for (int j = 0; j < l; j++) begin
                if (dispatch_valid[j] && (dest_arch[j] == src_arch[l])) begin
                    src_tag[l]   = alloc.tag[j];
                    src_ready[l] = 1'b0;  // producer not even dispatched yet
                end
                if (dispatch_valid[j] && (dest_arch[j] == dest_arch[l])) begin
                    old_tag[l] = alloc.tag[j];  // older lane's mapping is replaced
                end
            end
        end
    end

    // map after this cycle's dispatch
    always_comb begin
        next_map = map;
        if (alloc.ok) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (dispatch_valid[l]) begin
                    next_map[dest_arch[l]] = alloc.tag[l];  // lane 1 written last
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map[i]      <= phys_tag_t'(i);  // identity mapping
                ckpt_map[i] <= phys_tag_t'(i);
            end
        end else begin
            if (mispredict_restore) begin
                map <= ckpt_map;
            end else begin
                map <= next_map;
            end
            if (checkpoint_take) begin
                ckpt_map <= next_map;  // state as seen by the instruction after the branch
            end
        end
    end

endmodule

`default_nettype wire

//--- source/rename_top.sv
`timescale 1ns/10ps
`default_nettype none

// two-wide register rename stage
module rename_top import rename_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,

    // dispatch group
    input  logic      [NUM_LANES-1:0] dispatch_valid,
    input  arch_idx_t [NUM_LANES-1:0] dest_arch,
    input  arch_idx_t [NUM_LANES-1:0] src_arch,
    output logic                      dispatch_ok,   // low stalls the whole group
    output phys_tag_t [NUM_LANES-1:0] dest_tag,
    output phys_tag_t [NUM_LANES-1:0] old_tag,
    output phys_tag_t [NUM_LANES-1:0] src_tag,
    output logic      [NUM_LANES-1:0] src_ready,

    // writeback and commit
    input  logic      [NUM_LANES-1:0] complete_valid,
    input  phys_tag_t [NUM_LANES-1:0] complete_tag,
    input  logic      [NUM_LANES-1:0] retire_valid,
    input  phys_tag_t [NUM_LANES-1:0] retire_tag,

    // branch recovery
    input  logic                      checkpoint_take,
    input  logic                      mispredict_restore,
    output logic     [COUNT_BITS-1:0] free_count
);

    alloc_if alloc_bus ();

    map_table u_map (
        .clock              (clock),
        .reset              (reset),
        .dispatch_valid     (dispatch_valid),
        .dest_arch          (dest_arch),
        .src_arch           (src_arch),
        .checkpoint_take    (checkpoint_take),
        .mispredict_restore (mispredict_restore),
        .alloc              (alloc_bus.requester),
        .dispatch_ok        (dispatch_ok),
        .dest_tag           (dest_tag),
        .old_tag            (old_tag),
        .src_tag            (src_tag),
        .src_ready          (src_ready)
    );

    free_list u_free (
        .clock              (clock),
        .reset              (reset),
        .alloc              (alloc_bus.provider),
        .complete_valid     (complete_valid),
        .complete_tag       (complete_tag),
        .retire_valid       (retire_valid),
        .retire_tag         (retire_tag),
        .checkpoint_take    (checkpoint_take),
        .mispredict_restore (mispredict_restore),
        .free_count         (free_count)
    );

endmodule

`default_nettype wire

//--- sim/rename_sva.sv
`timescale 1ns/10ps
`default_nettype none

// free list invariants, bound into every free_list
module rename_sva import rename_pkg::*; (
    input logic                      clock,
    input logic                      reset,
    input phys_vec_t                 free_vec,
    input phys_vec_t                 alloc_vec,
    input logic      [NUM_LANES-1:0] retire_valid,
    input phys_tag_t [NUM_LANES-1:0] retire_tag,
    input logic      [NUM_LANES-1:0] fire,
    input phys_tag_t [NUM_LANES-1:0] grant_tag
);

    a_retire0_not_free: assert property (@(posedge clock) disable iff (reset)
        retire_valid[0] |-> !free_vec[retire_tag[0]]) else $error("lane 0 retired a free tag");
    a_retire1_not_free: assert property (@(posedge clock) disable iff (reset)
        retire_valid[1] |-> !free_vec[retire_tag[1]]) else $error("lane 1 retired a free tag");

    // grants only ever come out of the free pool
    a_grant_was_free: assert property (@(posedge clock) disable iff (reset)
        (alloc_vec & ~free_vec) == '0) else $error("granted tag was not free");

    a_grants_distinct: assert property (@(posedge clock) disable iff (reset)
        (&fire) |-> (grant_tag[0] != grant_tag[1])) else $error("both lanes got one tag");

endmodule

bind free_list rename_sva sva (
    .clock(clock), .reset(reset), .free_vec(free_vec),
    .alloc_vec(alloc_vec), .retire_valid(retire_valid), .retire_tag(retire_tag),
    .fire(fire), .grant_tag(grant_tag)
);

`default_nettype wire

//--- sim/rename_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rename_tb import rename_pkg::*; ();

    logic clock, reset, dispatch_ok, checkpoint_take, mispredict_restore;
    logic      [NUM_LANES-1:0] dispatch_valid, complete_valid, retire_valid, src_ready;
    arch_idx_t [NUM_LANES-1:0] dest_arch, src_arch;
    phys_tag_t [NUM_LANES-1:0] dest_tag, old_tag, src_tag, complete_tag, retire_tag;
    logic     [COUNT_BITS-1:0] free_count;

    int        seed = 32'h4ba7_1550;
    phys_tag_t m_map [ARCH_REGS];      // model map
    phys_tag_t ck_map [ARCH_REGS];     // model checkpoint
    phys_vec_t m_free, m_ready, ck_free;
    phys_tag_t inflight [$];           // old tags in program order
    phys_tag_t pending [$];            // allocated, not yet complete
    int        ck_len;                 // inflight entries older than the branch
    logic      ck_active;
    int        waited;

    rename_top uut (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic check_tag(input string name, input phys_tag_t got, input phys_tag_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input logic [COUNT_BITS-1:0] got,
                               input logic [COUNT_BITS-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    function automatic int count_free(input phys_vec_t v);
        count_free = 0;
        for (int i = 0; i < PHYS_REGS; i++) begin
            count_free += int'(v[i]);
        end
    endfunction

    // first set bit counting up from tag 0
    function automatic phys_tag_t lowest_free(input phys_vec_t v);
        for (int i = 0; i < PHYS_REGS; i++) begin
            if (v[i]) begin
                return phys_tag_t'(i);
            end
        end
        return '0;
    endfunction

    // one dispatch cycle: drive, predict, check at negedge, then advance the model
    task automatic run_cycle(input logic [1:0] dv, input arch_idx_t d0, d1, s0, s1,
                             input logic ckpt, restore, input int nret, ncomp);
        arch_idx_t d [2];
        arch_idx_t s [2];
        phys_tag_t t [2];
        phys_tag_t rt [2];
        phys_tag_t ct [2];
        phys_tag_t exp_old [2];
        phys_tag_t exp_src [2];
        logic      exp_rdy [2];
        logic [1:0] rv, cv;
        logic      ok;
        int        k;
        phys_vec_t f, post, alloc;

        d = '{d0, d1};
        s = '{s0, s1};
        rv = '0;
        cv = '0;
        rt = '{default: '0};
        ct = '{default: '0};
        for (int l = 0; l < NUM_LANES; l++) begin
            if (l < nret && inflight.size() > 0 && (!ck_active || ck_len > 0)) begin
                rt[l] = inflight.pop_front();  // retire strictly in order
                rv[l] = 1'b1;
                if (ck_active) ck_len--;
            end
            if (l < ncomp && pending.size() > 0) begin
                k = {$random(seed)} % pending.size();
                ct[l] = pending[k];
                pending.delete(k);
                cv[l] = 1'b1;
            end
        end
        @(posedge clock);
        dispatch_valid     <= dv;
        dest_arch          <= {d1, d0};
        src_arch           <= {s1, s0};
        retire_valid       <= rv;
        retire_tag         <= {rt[1], rt[0]};
        complete_valid     <= cv;
        complete_tag       <= {ct[1], ct[0]};
        checkpoint_take    <= ckpt;
        mispredict_restore <= restore;
        ok = (count_free(m_free) >= int'(dv[0]) + int'(dv[1])) && !restore;
        f = m_free;
        for (int l = 0; l < NUM_LANES; l++) begin
            t[l] = lowest_free(f);  // lower lane takes the lowest free tag
            if (dv[l]) f[t[l]] = 1'b0;
            exp_src[l] = m_map[s[l]];
            exp_rdy[l] = m_ready[exp_src[l]];
            exp_old[l] = m_map[d[l]];
        end
        if (dv[0] && d[0] == s[1]) begin
            exp_src[1] = t[0];
            exp_rdy[1] = 1'b0;
        end
        if (dv[0] && d[0] == d[1]) exp_old[1] = t[0];
        @(negedge clock);
        check_bit("dispatch_ok", dispatch_ok, ok);
        check_count("free_count", free_count, COUNT_BITS'(count_free(m_free)));
        for (int l = 0; l < NUM_LANES && ok; l++) begin
            check_tag($sformatf("src_tag[%0d]", l), src_tag[l], exp_src[l]);
            check_bit($sformatf("src_ready[%0d]", l), src_ready[l], exp_rdy[l]);
            if (dv[l]) begin
                check_tag($sformatf("dest_tag[%0d]", l), dest_tag[l], t[l]);
                check_tag($sformatf("old_tag[%0d]", l), old_tag[l], exp_old[l]);
            end
        end
        post = m_free;
        alloc = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (ok && dv[l]) begin
                post[t[l]] = 1'b0;
                alloc[t[l]] = 1'b1;
                m_map[d[l]] = t[l];
                inflight.push_back(exp_old[l]);
                pending.push_back(t[l]);
            end
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            if (rv[l]) post[rt[l]] = 1'b1;
            if (cv[l]) m_ready[ct[l]] = 1'b1;
        end
        m_ready = m_ready & ~alloc;
        if (ckpt) begin
            ck_map = m_map;
            ck_free = post;
            ck_len = inflight.size();
            ck_active = 1'b1;
        end
        m_free = post;
        if (restore) begin
            m_map = ck_map;
            m_free = post | ck_free;  // younger tags rejoin the pool
            while (inflight.size() > ck_len) void'(inflight.pop_back());
            ck_active = 1'b0;
        end
        for (int j = pending.size() - 1; j >= 0; j--) begin
            if (m_free[pending[j]]) begin
                pending.delete(j);  // freed before it ever completed
            end
        end
    endtask

    task automatic random_cycle(input logic ckpt, restore, input int nret);
        logic [31:0] rnd;

        rnd = $random(seed);
        run_cycle(rnd[1:0], rnd[4:2], rnd[7:5], rnd[10:8], rnd[13:11], ckpt, restore,
                  nret < 0 ? int'(rnd[15:14]) % 3 : nret, int'(rnd[17:16]) % 3);
    endtask

    initial begin
        reset = 1'b1;
        dispatch_valid = '0;
        dest_arch = '0;
        src_arch = '0;
        complete_valid = '0;
        complete_tag = '0;
        retire_valid = '0;
        retire_tag = '0;
        checkpoint_take = 1'b0;
        mispredict_restore = 1'b0;
        for (int i = 0; i < ARCH_REGS; i++) m_map[i] = phys_tag_t'(i);
        m_free = 16'hff00;
        m_ready = 16'h00ff;
        ck_active = 1'b0;
        ck_len = 0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        for (int k = 0; k < 4; k++)  // identity map, all sources ready
            run_cycle(2'b00, '0, '0, arch_idx_t'(2 * k), arch_idx_t'(2 * k + 1), 0, 0, 0, 0);
        repeat (300) random_cycle(1'b0, 1'b0, -1);

        // drain the pool, then stall, then retire until dispatch resumes
        waited = 0;
        while (count_free(m_free) >= 2) begin
            if (waited == 100) begin
                $display("timeout: the free list never drained without retires");
                $display("STATUS: FAIL");
                $fatal(1);
            end
            random_cycle(1'b0, 1'b0, 0);
            waited++;
        end
        run_cycle(2'b11, 3'd1, 3'd2, 3'd3, 3'd4, 0, 0, 0, 0);
        waited = 0;
        while (!dispatch_ok) begin
            if (waited == 20) begin
                $display("timeout: dispatch_ok stayed low while tags were retired");
                $display("STATUS: FAIL");
                $fatal(1);
            end
            run_cycle(2'b11, 3'd1, 3'd2, 3'd3, 3'd4, 0, 0, 1, 1);
            waited++;
        end

        // checkpoint, wrong path, restore with retires in the same cycle
        random_cycle(1'b1, 1'b0, -1);
        repeat (6) random_cycle(1'b0, 1'b0, -1);
        random_cycle(1'b0, 1'b1, 2);
        for (int k = 0; k < 4; k++)  // every lookup now sees the checkpointed map
            run_cycle(2'b00, '0, '0, arch_idx_t'(2 * k), arch_idx_t'(2 * k + 1), 0, 0, 0, 0);
        repeat (100) random_cycle(1'b0, 1'b0, -1);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
source/rename_pkg.sv
source/alloc_if.sv
source/psel_gen.sv
source/free_list.sv
source/map_table.sv
source/rename_top.sv
sim/rename_sva.sv
sim/rename_tb.sv

//--- Makefile
# Verilator build and run of the rename stage testbench
VERILATOR ?= verilator
TOP       ?= rename_tb
FLIST     ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "test did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
